//--- Makefile
TOP = rssMeterTb
SRCS = $(wildcard verilog/*.sv test/*.sv)

.PHONY: all run lint clean

all: run

obj_dir/V$(TOP): sim.f $(SRCS)
	verilator --binary --timing --assert -j 0 -f sim.f --top-module $(TOP)

run: obj_dir/V$(TOP)
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^STATUS: PASS$$"

lint:
	verilator --lint-only --timing --assert -Wall -f sim.f --top-module $(TOP)

clean:
	rm -rf obj_dir

//--- sim.f
verilog/rssPkg.sv
verilog/energyAccum.sv
verilog/energyFifo.sv
verilog/isqrtPipe.sv
verilog/rssMeter.sv
test/rssMeter_props.sv
test/rssMeterTb.sv

//--- test/rssMeterTb.sv
`timescale 1ns/1ps

module rssMeterTb;

  import rssPkg::*;

  localparam int WIN = 8;
  localparam int DEPTH = 4;
  localparam int RESET_CYCLES = 4;
  localparam int IDLE_CYCLES = 20;
  localparam int N_DIRECTED = 7;
  localparam int N_RANDOM = 200;
  localparam int N_STALL = 12;
  localparam int N_TOGGLE = 40;
  localparam int TOTAL_WINDOWS = N_DIRECTED + N_RANDOM + N_STALL + N_TOGGLE + 2;
  localparam int TOTAL_SAMPLES = TOTAL_WINDOWS * WIN;
  localparam int STALL_CYCLES = RESET_CYCLES + IDLE_CYCLES + N_STALL * WIN + 8;
  localparam int WATCHDOG_CYCLES = TOTAL_SAMPLES * 2 + STALL_CYCLES + 200;

  logic             clk = 1'b0;
  logic             rstN;
  logic             sampleVld;
  sample_t          sample;
  logic             en;
  logic             outVld;
  rssRec_t          result;
  logic             overflow;
  logic [TAG_W-1:0] dropCount;

  integer           seed = 32'hbe76;
  sample_t          winBuf [WIN];
  longint unsigned  expSum [TOTAL_WINDOWS];  // expected sum per window in send order.
  int               winCount = 0;
  int               nextIdx = 0;
  int               rxCount = 0;
  int               skipCount = 0;
  int               errCount = 0;
  int               checkCount = 0;
  int               errMark = 0;
  int               gap;
  longint unsigned  expRoot;
  logic             enLast = 1'b0;

  always #2 clk = ~clk;

  rssMeter #(
    .WINDOW(WIN),
    .FIFO_DEPTH(DEPTH)
  ) rssMeter_inst (
    .clk(clk),
    .rstN(rstN),
    .sampleVld(sampleVld),
    .sample(sample),
    .en(en),
    .outVld(outVld),
    .result(result),
    .overflow(overflow),
    .dropCount(dropCount)
  );

  // digit-by-digit root that settles one result bit per power of four.
  function automatic longint unsigned refIsqrt(longint unsigned n);
    longint unsigned rem;
    longint unsigned res;
    longint unsigned one;
    rem = n;
    res = 0;
    one = 64'd1 << 38;
    while (one > rem) begin
      one = one >> 2;
    end
    while (one != 0) begin
      if (rem >= res + one) begin
        rem = rem - (res + one);
        res = (res >> 1) + one;
      end else begin
        res = res >> 1;
      end
      one = one >> 2;
    end
    return res;
  endfunction

  task automatic reportMismatch(input string name, input longint unsigned got,
                                input longint unsigned want);
    errCount++;
    $display("[ERROR] %s: got 0x%0h expected 0x%0h", name, got, want);
  endtask

  task automatic finishTest(input string name);
    $display("test %s: %0d errors", name, errCount - errMark);
    errMark = errCount;
  endtask

  task automatic fillConst(input sample_t v);
    for (int i = 0; i < WIN; i++) begin
      winBuf[i] = v;
    end
  endtask

  task automatic fillRandom();
    for (int i = 0; i < WIN; i++) begin
      winBuf[i] = sample_t'($random(seed));
    end
  endtask

  // entered on a falling edge and left on the falling edge after the last sample.
  task automatic sendWindow(input bit gaps, input bit toggleEn);
    longint unsigned acc;
    acc = 0;
    for (int i = 0; i < WIN; i++) begin
      if (gaps && (($random(seed) & 3) == 0)) begin
        sampleVld = 1'b0;
        if (toggleEn) begin
          en = ($random(seed) & 1) != 0;
        end
        @(negedge clk);
      end
      sampleVld = 1'b1;
      sample = winBuf[i];
      if (toggleEn) begin
        en = ($random(seed) & 1) != 0;
      end
      acc += longint'(winBuf[i]) * longint'(winBuf[i]);
      @(negedge clk);
    end
    sampleVld = 1'b0;
    expSum[winCount] = acc;
    winCount++;
  endtask

  // every window sent is either a result or a counted drop.
  task automatic drainWait();
    while (rxCount + int'(dropCount) != winCount) begin
      @(negedge clk);
    end
  endtask

  initial begin
    rstN = 1'b0;
    sampleVld = 1'b0;
    sample = '0;
    en = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    rstN = 1'b1;

    repeat (IDLE_CYCLES) begin
      @(negedge clk);
      checkCount++;
      if (outVld != 1'b0 || overflow != 1'b0 || dropCount != '0) begin
        reportMismatch("outVld/overflow/dropCount",
                       64'({outVld, overflow, dropCount}), 64'd0);
      end
    end
    finishTest("1 idle after reset");

    fillConst(sample_t'(0));
    sendWindow(1'b0, 1'b0);
    fillConst(sample_t'(-32768));
    sendWindow(1'b0, 1'b0);
    fillConst(sample_t'(6930));  // 8 * 6930**2 is 19601**2 - 1.
    sendWindow(1'b0, 1'b0);
    fillConst(sample_t'(1));
    sendWindow(1'b0, 1'b0);
    fillConst(sample_t'(0));
    winBuf[0] = sample_t'(3);
    winBuf[1] = sample_t'(4);
    sendWindow(1'b0, 1'b0);
    fillConst(sample_t'(0));
    winBuf[2] = sample_t'(30000);
    winBuf[5] = sample_t'(-16000);  // sum is 34000**2.
    sendWindow(1'b0, 1'b0);
    fillConst(sample_t'(0));
    for (int i = 0; i < 4; i++) begin
      winBuf[i] = sample_t'(16384);
    end
    sendWindow(1'b0, 1'b0);
    drainWait();
    finishTest("2 directed windows");

    repeat (N_RANDOM) begin
      fillRandom();
      sendWindow(1'b0, 1'b0);
    end
    drainWait();
    checkCount++;
    if (dropCount != '0) begin
      reportMismatch("dropCount", 64'(dropCount), 64'd0);
    end
    checkCount++;
    if (overflow != 1'b0) begin
      reportMismatch("overflow", 64'(overflow), 64'd0);
    end
    checkCount++;
    if (skipCount != 0) begin
      errCount++;
      $display("%0d tags were skipped in a run that should drop nothing", skipCount);
    end
    finishTest("3 random back to back");

    en = 1'b0;
    repeat (N_STALL) begin
      fillRandom();
      sendWindow(1'b0, 1'b0);
    end
    repeat (4) @(negedge clk);
    checkCount++;
    if (int'(dropCount) != N_STALL - DEPTH) begin
      reportMismatch("dropCount", 64'(dropCount), 64'(N_STALL - DEPTH));
    end
    checkCount++;
    if (overflow != 1'b1) begin
      reportMismatch("overflow", 64'(overflow), 64'd1);
    end
    en = 1'b1;
    drainWait();
    fillRandom();
    sendWindow(1'b0, 1'b0);  // its tag exposes the dropped run.
    drainWait();
    checkCount++;
    if (int'(dropCount) != skipCount) begin
      reportMismatch("dropCount", 64'(dropCount), 64'(skipCount));
    end
    finishTest("4 stall with overflow");

    repeat (N_TOGGLE) begin
      fillRandom();
      sendWindow(1'b1, 1'b1);
    end
    en = 1'b1;
    drainWait();
    fillRandom();
    sendWindow(1'b0, 1'b0);
    drainWait();
    checkCount++;
    if (int'(dropCount) != skipCount) begin
      reportMismatch("dropCount", 64'(dropCount), 64'(skipCount));
    end
    finishTest("5 random en toggling");

    $display("summary: %0d checks, %0d errors", checkCount, errCount);
    if (errCount == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

  // a result is new only if the edge that loaded it had en high.
  always @(posedge clk) begin
    if (rstN && outVld && enLast) begin
      gap = (int'(result.tag) - nextIdx) & ((1 << TAG_W) - 1);
      skipCount += gap;
      nextIdx += gap;
      checkCount++;
      if (nextIdx >= winCount) begin
        errCount++;
        $display("result with tag 0x%0h came out of order or for a window never sent",
                 result.tag);
      end else begin
        expRoot = refIsqrt(expSum[nextIdx]);
        if (result.root != ROOT_W'(expRoot)) begin
          reportMismatch("result.root", 64'(result.root), expRoot);
        end
      end
      nextIdx++;
      rxCount++;
    end
    enLast = en;
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("watchdog: the run timed out before all results arrived");
    $display("STATUS: FAIL");
    $finish;
  end

endmodule

//--- test/rssMeter_props.sv
`timescale 1ns/1ps

module rssMeterProps (
  input logic                      clk,
  input logic                      rstN,
  input logic                      en,
  input logic                      outVld,
  input rssPkg::rssRec_t           result,
  input logic                      overflow,
  input logic [rssPkg::TAG_W-1:0]  dropCount
);

  outVldLowAfterReset: assert property (@(posedge clk) !rstN |=> !outVld)
    else $error("outVld was high in the cycle after reset");

  overflowSticky: assert property (@(posedge clk) (rstN && overflow) |=> overflow)
    else $error("overflow fell without a reset");

  dropCountMonotonic: assert property (@(posedge clk) rstN |=> (dropCount >= $past(dropCount)))
    else $error("dropCount decreased without a reset");

  // a stalled edge freezes the output register.
  outputHoldOnStall: assert property (@(posedge clk)
    (rstN && !en) |=> ($stable(outVld) && $stable(result)))
    else $error("outVld or result changed across a stalled edge");

endmodule

bind rssMeter rssMeterProps rssMeterProps_inst (
  .clk(clk),
  .rstN(rstN),
  .en(en),
  .outVld(outVld),
  .result(result),
  .overflow(overflow),
  .dropCount(dropCount)
);

//--- verilog/energyAccum.sv
`timescale 1ns/1ps

module energyAccum #(
  parameter int WINDOW = 256
) (
  input  logic                clk,
  input  logic                rstN,
  input  logic                sampleVld,
  input  rssPkg::sample_t     sample,
  output logic                recVld,
  output rssPkg::energyRec_t  rec
);

  import rssPkg::*;

  localparam int CNT_W = (WINDOW > 1) ? $clog2(WINDOW) : 1;

  // a window longer than 1023 full-scale samples would wrap the sum.
  if (WINDOW < 1 || WINDOW > 1023) begin : gBadWindow
    $error("energyAccum: WINDOW must be in 1..1023, got %0d", WINDOW);
  end

  logic [2*SAMPLE_W-1:0] square;
  logic [SUM_W-1:0]      sum;
  logic [SUM_W-1:0]      sumNext;
  logic [CNT_W-1:0]      cnt;
  logic [TAG_W-1:0]      tag;
  logic                  lastSample;

  // both operands are sign-extended first, so the product is the exact square.
  assign square = (2*SAMPLE_W)'(sample) * (2*SAMPLE_W)'(sample);  // at most 2**30.

  assign sumNext = sum + SUM_W'(square);

  assign lastSample = sampleVld && (cnt == CNT_W'(WINDOW - 1));

  always_ff @(posedge clk) begin
    if (!rstN) begin
      sum <= '0;
      cnt <= '0;
      tag <= '0;
      recVld <= 1'b0;
    end else begin
      recVld <= lastSample;
      if (sampleVld) begin
        if (lastSample) begin
          sum <= '0;  // next window starts clean in the same edge.
          cnt <= '0;
          tag <= tag + 1'b1;  // wraps after 256 windows.
        end else begin
          sum <= sumNext;
          cnt <= cnt + 1'b1;
        end
      end
    end
  end

  // the finished record is only loaded at a window end.
  always_ff @(posedge clk) begin
    if (lastSample) begin
      rec.sum <= sumNext;
      rec.tag <= tag;
    end
  end

endmodule

//--- verilog/energyFifo.sv
`timescale 1ns/1ps

module energyFifo #(
  parameter int FIFO_DEPTH = 8
) (
  input  logic                        clk,
  input  logic                        rstN,
  input  logic                        recVld,
  input  rssPkg::energyRec_t          rec,
  input  logic                        en,
  output logic                        rootVld,
  output rssPkg::energyRec_t          rootIn,
  output logic                        overflow,
  output logic [rssPkg::TAG_W-1:0]    dropCount
);

  import rssPkg::*;

  localparam int PTR_W = $clog2(FIFO_DEPTH);

  if (FIFO_DEPTH < 2 || (FIFO_DEPTH & (FIFO_DEPTH - 1)) != 0) begin : gBadDepth
    $error("energyFifo: FIFO_DEPTH must be a power of two >= 2, got %0d", FIFO_DEPTH);
  end

  energyRec_t       mem [FIFO_DEPTH];
  logic [PTR_W-1:0] wrPtr;
  logic [PTR_W-1:0] rdPtr;
  logic [PTR_W:0]   count;
  logic             full;
  logic             empty;
  logic             push;
  logic             pop;
  logic             rootVldQ;

  assign full = (count == (PTR_W+1)'(FIFO_DEPTH));
  assign empty = (count == '0);
  assign push = recVld && !full;  // a record arriving when full is lost.
  assign pop = en && !empty;

  // the head register only moves on en edges, so a popped entry waits there
  // through a stall and is taken by the root unit on the next en-high edge.
  assign rootVld = rootVldQ && en;

  always_ff @(posedge clk) begin
    if (push) begin
      mem[wrPtr] <= rec;
    end
  end

  always_ff @(posedge clk) begin
    if (pop) begin
      rootIn <= mem[rdPtr];
    end
  end

  always_ff @(posedge clk) begin
    if (!rstN) begin
      wrPtr <= '0;
      rdPtr <= '0;
      count <= '0;
      rootVldQ <= 1'b0;
      overflow <= 1'b0;
      dropCount <= '0;
    end else begin
      if (push) begin
        wrPtr <= wrPtr + 1'b1;  // depth is a power of two, so it wraps itself.
      end
      if (pop) begin
        rdPtr <= rdPtr + 1'b1;
      end
      case ({push, pop})
        2'b10: count <= count + 1'b1;
        2'b01: count <= count - 1'b1;
        default: count <= count;
      endcase
      if (en) begin
        rootVldQ <= pop;
      end
      if (recVld && full) begin
        overflow <= 1'b1;
        if (dropCount != '1) begin
          dropCount <= dropCount + 1'b1;  // Saturates at all ones.
        end
      end
    end
  end

endmodule

//--- verilog/isqrtPipe.sv
`timescale 1ns/1ps

module isqrtPipe (
  input  logic                clk,
  input  logic                rstN,
  input  logic                en,
  input  logic                rootVld,
  input  rssPkg::energyRec_t  rootIn,
  output logic                outVld,
  output rssPkg::rssRec_t     result
);

  import rssPkg::*;

  localparam int STAGES = 4;  // register groups holding partial roots.
  localparam int BITS_PER = ROOT_W / STAGES;  // root bits resolved per stage.

  // state of one root in flight.
  typedef struct packed {
    logic [SUM_W-1:0]  operand;
    logic [ROOT_W-1:0] root;
    logic [SUM_W-1:0]  sq;
    logic [TAG_W-1:0]  tag;
  } stage_t;

  // resolves BITS_PER root bits from bit hi downward.
  // a bit is kept when (root + 2**b)**2 = sq + 2**(2b) + root * 2**(b+1)
  // still fits under the operand.
  function automatic stage_t rootBits(stage_t s, int hi);
    stage_t           r;
    logic [SUM_W-1:0] trial;
    int               b;
    r = s;
    for (int i = 0; i < BITS_PER; i++) begin
      b = hi - i;
      trial = r.sq + (SUM_W'(1) << (2 * b)) + (SUM_W'(r.root) << (b + 1));
      if (trial <= r.operand) begin
        r.sq = trial;
        r.root = r.root | (ROOT_W'(1) << b);
      end
    end
    return r;
  endfunction

  stage_t             pipe [STAGES];
  stage_t             lastStep;
  logic [STAGES-1:0]  vld;

  assign lastStep = rootBits(pipe[STAGES-1], BITS_PER - 1);

  // payload registers. pipe[0] is the input register and pipe[k] holds the
  // partial root after bit ROOT_W - BITS_PER*k.
  always_ff @(posedge clk) begin
    if (en) begin
      pipe[0].operand <= rootIn.sum;
      pipe[0].root <= '0;
      pipe[0].sq <= '0;  // the first step starts from a zero square.
      pipe[0].tag <= rootIn.tag;
      for (int k = 1; k < STAGES; k++) begin
        pipe[k] <= rootBits(pipe[k-1], ROOT_W - 1 - BITS_PER * (k - 1));
      end
      result.root <= lastStep.root;
      result.tag <= lastStep.tag;
    end
  end

  always_ff @(posedge clk) begin
    if (!rstN) begin
      vld <= '0;
      outVld <= 1'b0;
    end else if (en) begin
      vld <= {vld[STAGES-2:0], rootVld};
      outVld <= vld[STAGES-1];  // held while en is low just like the data.
    end
  end

endmodule

//--- verilog/rssMeter.sv
`timescale 1ns/1ps

module rssMeter #(
  parameter int WINDOW = 256,
  parameter int FIFO_DEPTH = 8
) (
  input  logic                      clk,
  input  logic                      rstN,
  input  logic                      sampleVld,
  input  rssPkg::sample_t           sample,
  input  logic                      en,
  output logic                      outVld,
  output rssPkg::rssRec_t           result,
  output logic                      overflow,
  output logic [rssPkg::TAG_W-1:0]  dropCount
);

  import rssPkg::*;

  logic       recVld;
  energyRec_t rec;
  logic       rootVld;
  energyRec_t rootIn;

  energyAccum #(
    .WINDOW(WINDOW)
  ) energyAccum_inst (
    .clk(clk),
    .rstN(rstN),
    .sampleVld(sampleVld),
    .sample(sample),
    .recVld(recVld),
    .rec(rec)
  );

  // this buffer absorbs the windows that finish while en is low.
  energyFifo #(
    .FIFO_DEPTH(FIFO_DEPTH)
  ) energyFifo_inst (
    .clk(clk),
    .rstN(rstN),
    .recVld(recVld),
    .rec(rec),
    .en(en),
    .rootVld(rootVld),
    .rootIn(rootIn),
    .overflow(overflow),
    .dropCount(dropCount)
  );

  isqrtPipe isqrtPipe_inst (
    .clk(clk),
    .rstN(rstN),
    .en(en),
    .rootVld(rootVld),
    .rootIn(rootIn),
    .outVld(outVld),
    .result(result)
  );

endmodule

//--- verilog/rssPkg.sv
package rssPkg;

  localparam int SAMPLE_W = 16;
  localparam int SUM_W = 40;  // holds up to 1023 full-scale squares.
  localparam int ROOT_W = 20;  // floor root of a SUM_W-bit value.
  localparam int TAG_W = 8;

  // raw input sample in two's complement.
  typedef logic signed [SAMPLE_W-1:0] sample_t;

  // one finished window sum with its sequence tag.
  typedef struct packed {
    logic [SUM_W-1:0] sum;
    logic [TAG_W-1:0] tag;
  } energyRec_t;

  // root of one window sum with the tag carried over unchanged.
  typedef struct packed {
    logic [ROOT_W-1:0] root;
    logic [TAG_W-1:0] tag;
  } rssRec_t;

endpackage
